// File: rtl/rob_pkg.sv
package rob_pkg;

    localparam int DATA_W  = 32;
    localparam int REG_W   = 5;
    localparam int MSIZE_W = 2;

    // one 64-bit result word decoded by the port that completed the entry
    typedef union packed {
        struct packed {
            logic [DATA_W-1:0] zero;
            logic [DATA_W-1:0] data;
        } alu;
        struct packed {
            logic [DATA_W-1:0] addr;
            logic [DATA_W-1:0] wdata;
        } mem;
        struct packed {
            logic [DATA_W-1:0] target;
            logic [DATA_W-2:0] zero;
            logic              taken;
        } branch;
    } rob_result_u;

endpackage

// File: rtl/rob_ptr_ctrl.sv
`timescale 1ns/100ps

module rob_ptr_ctrl #(
    parameter int ROB_DEPTH = 16,
    localparam int ADDR_W = $clog2(ROB_DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  logic [ADDR_W:0]   retire_cnt,
    input  logic              squash,
    output logic [ADDR_W-1:0] head_addr,
    output logic [ADDR_W-1:0] tail_addr,
    output logic [ADDR_W:0]   count,
    output logic              full
);

    // msb of each pointer is the wrap bit
    logic [ADDR_W:0] head_ptr;
    logic [ADDR_W:0] tail_ptr;

    always_ff @(posedge clk) begin
        if (rst || squash) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + retire_cnt;
            if (alloc) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    assign head_addr = head_ptr[ADDR_W-1:0];
    assign tail_addr = tail_ptr[ADDR_W-1:0];

    // never exceeds ROB_DEPTH, so the modulo difference is exact
    assign count = tail_ptr - head_ptr;

    // same slot on a different lap
    assign full = (head_ptr[ADDR_W] != tail_ptr[ADDR_W]) &&
                  (head_addr == tail_addr);

endmodule

// File: rtl/rob_table.sv
`timescale 1ns/100ps

module rob_table #(
    parameter int ROB_DEPTH    = 16,
    parameter int RETIRE_WIDTH = 2,
    localparam int ADDR_W = $clog2(ROB_DEPTH)
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             squash,
    input  logic                                             alloc,
    input  logic [rob_pkg::REG_W-1:0]                        alloc_dst,
    input  logic [rob_pkg::DATA_W-1:0]                       alloc_pc,
    input  logic                                             alloc_is_branch,
    input  logic                                             alloc_is_store,
    input  logic [rob_pkg::MSIZE_W-1:0]                      alloc_msize,
    input  logic [ADDR_W-1:0]                                head_addr,
    input  logic [ADDR_W-1:0]                                tail_addr,
    input  logic                                             alu_cpl_valid,
    input  logic [ADDR_W-1:0]                                alu_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                       alu_cpl_data,
    input  logic                                             alu_cpl_exc,
    input  logic                                             mem_cpl_valid,
    input  logic [ADDR_W-1:0]                                mem_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                       mem_cpl_maddr,
    input  logic [rob_pkg::DATA_W-1:0]                       mem_cpl_wdata,
    input  logic                                             mem_cpl_exc,
    input  logic                                             br_cpl_valid,
    input  logic [ADDR_W-1:0]                                br_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                       br_cpl_target,
    input  logic                                             br_cpl_taken,
    input  logic                                             br_cpl_exc,
    input  logic [ADDR_W-1:0]                                src_addr,
    output logic                                             src_ready,
    output logic [rob_pkg::DATA_W-1:0]                       src_data,
    output logic [RETIRE_WIDTH-1:0]                          win_complete,
    output logic [RETIRE_WIDTH-1:0]                          win_exc,
    output logic [RETIRE_WIDTH-1:0]                          win_is_branch,
    output logic [RETIRE_WIDTH-1:0]                          win_is_store,
    output logic [RETIRE_WIDTH-1:0][rob_pkg::MSIZE_W-1:0]    win_msize,
    output logic [RETIRE_WIDTH-1:0][rob_pkg::REG_W-1:0]      win_dst,
    output logic [RETIRE_WIDTH-1:0][rob_pkg::DATA_W-1:0]     win_pc,
    output rob_pkg::rob_result_u [RETIRE_WIDTH-1:0]          win_result
);

    import rob_pkg::*;

    logic [ROB_DEPTH-1:0] complete_q;
    logic [ROB_DEPTH-1:0] exc_q;
    logic [ROB_DEPTH-1:0] is_branch_q;
    logic [ROB_DEPTH-1:0] is_store_q;
    logic [MSIZE_W-1:0]   msize_q  [ROB_DEPTH];
    logic [REG_W-1:0]     dst_q    [ROB_DEPTH];
    logic [DATA_W-1:0]    pc_q     [ROB_DEPTH];
    rob_result_u          result_q [ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (rst || squash) begin
            complete_q <= '0;
        end else begin
            if (alloc) begin
                complete_q[tail_addr] <= 1'b0;
            end
            if (alu_cpl_valid) begin
                complete_q[alu_cpl_addr] <= 1'b1;
            end
            if (mem_cpl_valid) begin
                complete_q[mem_cpl_addr] <= 1'b1;
            end
            if (br_cpl_valid) begin
                complete_q[br_cpl_addr] <= 1'b1;
            end
        end
    end

    // each port fills its own view of the payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            exc_q[tail_addr]       <= 1'b0;
            is_branch_q[tail_addr] <= alloc_is_branch;
            is_store_q[tail_addr]  <= alloc_is_store;
            msize_q[tail_addr]     <= alloc_msize;
            dst_q[tail_addr]       <= alloc_dst;
            pc_q[tail_addr]        <= alloc_pc;
        end
        if (alu_cpl_valid) begin
            exc_q[alu_cpl_addr]             <= alu_cpl_exc;
            result_q[alu_cpl_addr].alu.zero <= '0;
            result_q[alu_cpl_addr].alu.data <= alu_cpl_data;
        end
        if (mem_cpl_valid) begin
            exc_q[mem_cpl_addr]              <= mem_cpl_exc;
            result_q[mem_cpl_addr].mem.addr  <= mem_cpl_maddr;
            result_q[mem_cpl_addr].mem.wdata <= mem_cpl_wdata;
        end
        if (br_cpl_valid) begin
            exc_q[br_cpl_addr]                  <= br_cpl_exc;
            result_q[br_cpl_addr].branch.target <= br_cpl_target;
            result_q[br_cpl_addr].branch.zero   <= '0;
            result_q[br_cpl_addr].branch.taken  <= br_cpl_taken;
        end
    end

    // operand lookup for issue
    assign src_ready = complete_q[src_addr];
    assign src_data  = result_q[src_addr].alu.data;

    // head window wraps around the table
    for (genvar i = 0; i < RETIRE_WIDTH; i++) begin : g_win
        logic [ADDR_W-1:0] idx;

        assign idx              = head_addr + ADDR_W'(i);
        assign win_complete[i]  = complete_q[idx];
        assign win_exc[i]       = exc_q[idx];
        assign win_is_branch[i] = is_branch_q[idx];
        assign win_is_store[i]  = is_store_q[idx];
        assign win_msize[i]     = msize_q[idx];
        assign win_dst[i]       = dst_q[idx];
        assign win_pc[i]        = pc_q[idx];
        assign win_result[i]    = result_q[idx];
    end

endmodule

// File: rtl/rob_retire_fsm.sv
`timescale 1ns/100ps

module rob_retire_fsm #(
    parameter int ROB_DEPTH    = 16,
    parameter int RETIRE_WIDTH = 2,
    localparam int ADDR_W = $clog2(ROB_DEPTH)
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush,
    input  logic [RETIRE_WIDTH-1:0]                       win_complete,
    input  logic [RETIRE_WIDTH-1:0]                       win_exc,
    input  logic [RETIRE_WIDTH-1:0]                       win_is_branch,
    input  logic [RETIRE_WIDTH-1:0]                       win_is_store,
    input  logic [RETIRE_WIDTH-1:0][rob_pkg::MSIZE_W-1:0] win_msize,
    input  logic [RETIRE_WIDTH-1:0][rob_pkg::REG_W-1:0]   win_dst,
    input  logic [RETIRE_WIDTH-1:0][rob_pkg::DATA_W-1:0]  win_pc,
    input  rob_pkg::rob_result_u [RETIRE_WIDTH-1:0]       win_result,
    input  logic [ADDR_W:0]                               count,
    input  logic                                          d_data_ok,
    output logic [ADDR_W:0]                               retire_cnt,
    output logic                                          squash,
    output logic [RETIRE_WIDTH-1:0]                       retire_valid,
    output logic [RETIRE_WIDTH-1:0][rob_pkg::REG_W-1:0]   retire_dst,
    output logic [RETIRE_WIDTH-1:0][rob_pkg::DATA_W-1:0]  retire_data,
    output logic                                          mem_wen,
    output logic [rob_pkg::DATA_W-1:0]                    mem_addr,
    output logic [rob_pkg::DATA_W-1:0]                    mem_wdata,
    output logic [rob_pkg::MSIZE_W-1:0]                   mem_size,
    output logic                                          redirect_valid,
    output logic [rob_pkg::DATA_W-1:0]                    redirect_pc,
    output logic                                          exc_valid,
    output logic [rob_pkg::DATA_W-1:0]                    exc_pc
);

    import rob_pkg::*;

    localparam logic RUN        = 1'b0;
    localparam logic STORE_WAIT = 1'b1;

    logic state;
    logic head_done;
    logic chain;

    // head entry present and finished
    assign head_done = (count != '0) && win_complete[0];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= RUN;
        end else if (state == RUN && mem_wen) begin
            state <= STORE_WAIT;
        end else if (state == STORE_WAIT && d_data_ok) begin
            state <= RUN;
        end
    end

    // store goes out once, then waits for the memory
    assign mem_wen   = (state == RUN) && head_done && !win_exc[0] && win_is_store[0];
    assign mem_addr  = win_result[0].mem.addr;
    assign mem_wdata = win_result[0].mem.wdata;
    assign mem_size  = win_msize[0];

    assign exc_valid = (state == RUN) && head_done && win_exc[0];
    assign exc_pc    = win_pc[0];

    always_comb begin
        retire_valid   = '0;
        retire_cnt     = '0;
        redirect_valid = 1'b0;
        redirect_pc    = win_result[0].branch.target;
        chain          = 1'b1;
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            if (chain && (count > i) && win_complete[i] && !win_exc[i]) begin
                if (win_is_store[i]) begin
                    // only the head store, and only once memory answers
                    if (i == 0 && state == STORE_WAIT && d_data_ok) begin
                        retire_valid[i] = 1'b1;
                        retire_cnt      = retire_cnt + 1'b1;
                    end
                    chain = 1'b0;
                end else begin
                    retire_valid[i] = 1'b1;
                    retire_cnt      = retire_cnt + 1'b1;
                    if (win_is_branch[i] && win_result[i].branch.taken) begin
                        redirect_valid = 1'b1;
                        redirect_pc    = win_result[i].branch.target;
                        chain          = 1'b0;
                    end
                end
            end else begin
                chain = 1'b0;
            end
        end
    end

    // per-slot writeback value
    always_comb begin
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            retire_dst[i] = win_dst[i];
            if (win_is_branch[i]) begin
                retire_data[i] = win_pc[i] + DATA_W'(8);
            end else if (win_is_store[i]) begin
                retire_data[i] = win_result[i].mem.wdata;
            end else begin
                retire_data[i] = win_result[i].alu.data;
            end
        end
    end

    assign squash = flush || redirect_valid || exc_valid;

endmodule

// File: rtl/rob_top.sv
`timescale 1ns/100ps

module rob_top #(
    parameter int ROB_DEPTH    = 16,
    parameter int RETIRE_WIDTH = 2,
    localparam int ADDR_W = $clog2(ROB_DEPTH)
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       flush,
    input  logic                                       alloc_valid,
    input  logic [rob_pkg::REG_W-1:0]                  alloc_dst,
    input  logic [rob_pkg::DATA_W-1:0]                 alloc_pc,
    input  logic                                       alloc_is_branch,
    input  logic                                       alloc_is_store,
    input  logic [rob_pkg::MSIZE_W-1:0]                alloc_msize,
    output logic                                       alloc_ready,
    output logic [ADDR_W-1:0]                          alloc_addr,
    input  logic                                       alu_cpl_valid,
    input  logic [ADDR_W-1:0]                          alu_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                 alu_cpl_data,
    input  logic                                       alu_cpl_exc,
    input  logic                                       mem_cpl_valid,
    input  logic [ADDR_W-1:0]                          mem_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                 mem_cpl_maddr,
    input  logic [rob_pkg::DATA_W-1:0]                 mem_cpl_wdata,
    input  logic                                       mem_cpl_exc,
    input  logic                                       br_cpl_valid,
    input  logic [ADDR_W-1:0]                          br_cpl_addr,
    input  logic [rob_pkg::DATA_W-1:0]                 br_cpl_target,
    input  logic                                       br_cpl_taken,
    input  logic                                       br_cpl_exc,
    input  logic [ADDR_W-1:0]                          src_addr,
    output logic                                       src_ready,
    output logic [rob_pkg::DATA_W-1:0]                 src_data,
    input  logic                                       d_data_ok,
    output logic [RETIRE_WIDTH-1:0]                    retire_valid,
    output logic [RETIRE_WIDTH*rob_pkg::REG_W-1:0]     retire_dst,
    output logic [RETIRE_WIDTH*rob_pkg::DATA_W-1:0]    retire_data,
    output logic                                       mem_wen,
    output logic [rob_pkg::DATA_W-1:0]                 mem_addr,
    output logic [rob_pkg::DATA_W-1:0]                 mem_wdata,
    output logic [rob_pkg::MSIZE_W-1:0]                mem_size,
    output logic                                       redirect_valid,
    output logic [rob_pkg::DATA_W-1:0]                 redirect_pc,
    output logic                                       exc_valid,
    output logic [rob_pkg::DATA_W-1:0]                 exc_pc
);

    import rob_pkg::*;

    logic                                  alloc;
    logic                                  full;
    logic                                  squash;
    logic [ADDR_W-1:0]                     head_addr;
    logic [ADDR_W-1:0]                     tail_addr;
    logic [ADDR_W:0]                       count;
    logic [ADDR_W:0]                       retire_cnt;
    logic [RETIRE_WIDTH-1:0]               win_complete;
    logic [RETIRE_WIDTH-1:0]               win_exc;
    logic [RETIRE_WIDTH-1:0]               win_is_branch;
    logic [RETIRE_WIDTH-1:0]               win_is_store;
    logic [RETIRE_WIDTH-1:0][MSIZE_W-1:0]  win_msize;
    logic [RETIRE_WIDTH-1:0][REG_W-1:0]    win_dst;
    logic [RETIRE_WIDTH-1:0][DATA_W-1:0]   win_pc;
    rob_result_u [RETIRE_WIDTH-1:0]        win_result;

    // full is the only back-pressure on rename
    assign alloc_ready = !full;
    assign alloc       = alloc_valid && !full;
    assign alloc_addr  = tail_addr;

    rob_ptr_ctrl #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_ptr_ctrl (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .retire_cnt (retire_cnt),
        .squash     (squash),
        .head_addr  (head_addr),
        .tail_addr  (tail_addr),
        .count      (count),
        .full       (full)
    );

    rob_table #(
        .ROB_DEPTH    (ROB_DEPTH),
        .RETIRE_WIDTH (RETIRE_WIDTH)
    ) u_table (
        .clk             (clk),
        .rst             (rst),
        .squash          (squash),
        .alloc           (alloc),
        .alloc_dst       (alloc_dst),
        .alloc_pc        (alloc_pc),
        .alloc_is_branch (alloc_is_branch),
        .alloc_is_store  (alloc_is_store),
        .alloc_msize     (alloc_msize),
        .head_addr       (head_addr),
        .tail_addr       (tail_addr),
        .alu_cpl_valid   (alu_cpl_valid),
        .alu_cpl_addr    (alu_cpl_addr),
        .alu_cpl_data    (alu_cpl_data),
        .alu_cpl_exc     (alu_cpl_exc),
        .mem_cpl_valid   (mem_cpl_valid),
        .mem_cpl_addr    (mem_cpl_addr),
        .mem_cpl_maddr   (mem_cpl_maddr),
        .mem_cpl_wdata   (mem_cpl_wdata),
        .mem_cpl_exc     (mem_cpl_exc),
        .br_cpl_valid    (br_cpl_valid),
        .br_cpl_addr     (br_cpl_addr),
        .br_cpl_target   (br_cpl_target),
        .br_cpl_taken    (br_cpl_taken),
        .br_cpl_exc      (br_cpl_exc),
        .src_addr        (src_addr),
        .src_ready       (src_ready),
        .src_data        (src_data),
        .win_complete    (win_complete),
        .win_exc         (win_exc),
        .win_is_branch   (win_is_branch),
        .win_is_store    (win_is_store),
        .win_msize       (win_msize),
        .win_dst         (win_dst),
        .win_pc          (win_pc),
        .win_result      (win_result)
    );

    rob_retire_fsm #(
        .ROB_DEPTH    (ROB_DEPTH),
        .RETIRE_WIDTH (RETIRE_WIDTH)
    ) u_retire_fsm (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .win_complete   (win_complete),
        .win_exc        (win_exc),
        .win_is_branch  (win_is_branch),
        .win_is_store   (win_is_store),
        .win_msize      (win_msize),
        .win_dst        (win_dst),
        .win_pc         (win_pc),
        .win_result     (win_result),
        .count          (count),
        .d_data_ok      (d_data_ok),
        .retire_cnt     (retire_cnt),
        .squash         (squash),
        .retire_valid   (retire_valid),
        .retire_dst     (retire_dst),
        .retire_data    (retire_data),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_size       (mem_size),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exc_valid      (exc_valid),
        .exc_pc         (exc_pc)
    );

endmodule

// File: testbench/rob_chk.sv
`timescale 1ns/100ps

module rob_chk #(
    parameter int ROB_DEPTH    = 16,
    parameter int RETIRE_WIDTH = 2,
    localparam int ADDR_W = $clog2(ROB_DEPTH)
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    redirect_valid,
    input logic                    exc_valid,
    input logic                    mem_wen,
    input logic [RETIRE_WIDTH-1:0] retire_valid,
    input logic                    alloc_ready,
    input logic [ADDR_W:0]         count
);

    // at most one of the three head events per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({redirect_valid, exc_valid, mem_wen}))
        else $error("redirect, exception and store issued together");

    // ones from slot 0 upward with no gaps
    assert property (@(posedge clk) disable iff (rst)
        (retire_valid & (retire_valid + 1'b1)) == '0)
        else $error("retire_valid not contiguous from slot 0");

    assert property (@(posedge clk) disable iff (rst)
        alloc_ready == (count != (ADDR_W + 1)'(ROB_DEPTH)))
        else $error("alloc_ready disagrees with occupancy");

endmodule

bind rob_top rob_chk #(
    .ROB_DEPTH    (ROB_DEPTH),
    .RETIRE_WIDTH (RETIRE_WIDTH)
) u_chk (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .exc_valid      (exc_valid),
    .mem_wen        (mem_wen),
    .retire_valid   (retire_valid),
    .alloc_ready    (alloc_ready),
    .count          (count)
);

// File: testbench/tb_rob.sv
`timescale 1ns/100ps

module tb_rob;

    import rob_pkg::*;

    localparam int DEPTH = 8;
    localparam int RW    = 2;
    localparam int AW    = $clog2(DEPTH);

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    alloc_valid;
    logic [REG_W-1:0]        alloc_dst;
    logic [DATA_W-1:0]       alloc_pc;
    logic                    alloc_is_branch;
    logic                    alloc_is_store;
    logic [MSIZE_W-1:0]      alloc_msize;
    logic                    alloc_ready;
    logic [AW-1:0]           alloc_addr;
    logic                    alu_cpl_valid;
    logic [AW-1:0]           alu_cpl_addr;
    logic [DATA_W-1:0]       alu_cpl_data;
    logic                    alu_cpl_exc;
    logic                    mem_cpl_valid;
    logic [AW-1:0]           mem_cpl_addr;
    logic [DATA_W-1:0]       mem_cpl_maddr;
    logic [DATA_W-1:0]       mem_cpl_wdata;
    logic                    mem_cpl_exc;
    logic                    br_cpl_valid;
    logic [AW-1:0]           br_cpl_addr;
    logic [DATA_W-1:0]       br_cpl_target;
    logic                    br_cpl_taken;
    logic                    br_cpl_exc;
    logic [AW-1:0]           src_addr;
    logic                    src_ready;
    logic [DATA_W-1:0]       src_data;
    logic                    d_data_ok;
    logic [RW-1:0]           retire_valid;
    logic [RW*REG_W-1:0]     retire_dst;
    logic [RW*DATA_W-1:0]    retire_data;
    logic                    mem_wen;
    logic [DATA_W-1:0]       mem_addr;
    logic [DATA_W-1:0]       mem_wdata;
    logic [MSIZE_W-1:0]      mem_size;
    logic                    redirect_valid;
    logic [DATA_W-1:0]       redirect_pc;
    logic                    exc_valid;
    logic [DATA_W-1:0]       exc_pc;

    // top 4 bits give the record kind (1 retire, 2 store, 3 redirect, 4 exception)
    logic [71:0] rec_q[$];
    int          errors;
    int          test_errs;
    int          tests;
    int          failed_tests;
    int          fd;
    string       line;

    rob_top #(
        .ROB_DEPTH    (DEPTH),
        .RETIRE_WIDTH (RW)
    ) dut (.*);

    always #50 clk = ~clk;

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < RW; i++) begin
                if (retire_valid[i]) begin
                    rec_q.push_back({4'd1, 68'({retire_dst[i*REG_W +: REG_W],
                                                retire_data[i*DATA_W +: DATA_W]})});
                end
            end
            if (mem_wen) begin
                rec_q.push_back({4'd2, 68'({mem_size, mem_addr, mem_wdata})});
            end
            if (redirect_valid) begin
                rec_q.push_back({4'd3, 68'(redirect_pc)});
            end
            if (exc_valid) begin
                rec_q.push_back({4'd4, 68'(exc_pc)});
            end
        end
    end

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_value(input string name, input logic [71:0] exp,
                               input logic [71:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            note_error();
        end
    endtask

    task automatic expect_record(input string name, input logic [71:0] exp);
        logic [71:0] rec;
        int          waited;
        waited = 0;
        while (rec_q.size() == 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (rec_q.size() == 0) begin
            $display("ERROR: %s: no output record arrived within 200 cycles", name);
            note_error();
        end else begin
            rec = rec_q.pop_front();
            check_value(name, exp, rec);
        end
    endtask

    task automatic clear_strobes();
        alloc_valid   <= 1'b0;
        alu_cpl_valid <= 1'b0;
        mem_cpl_valid <= 1'b0;
        br_cpl_valid  <= 1'b0;
        flush         <= 1'b0;
    endtask

    task automatic run_expect(input string line);
        string       op;
        string       name;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        void'($sscanf(line, "%s %s %h %h %h", op, name, f1, f2, f3));
        case (op)
            "ER": expect_record(name, {4'd1, 68'({f1[REG_W-1:0], f2})});
            "ES": expect_record(name, {4'd2, 68'({f3[MSIZE_W-1:0], f1, f2})});
            "ED": expect_record(name, {4'd3, 68'(f1)});
            "EX": expect_record(name, {4'd4, 68'(f1)});
            "EO": begin
                @(posedge clk);
                src_addr <= f1[AW-1:0];
                @(negedge clk);
                check_value(name, 72'(f2[0]), 72'(src_ready));
                if (f2[0]) begin
                    check_value(name, 72'(f3), 72'(src_data));
                end
            end
            "EA": begin
                @(negedge clk);
                check_value(name, 72'({f1[0], f2[AW-1:0]}), 72'({alloc_ready, alloc_addr}));
            end
            "EE": begin
                @(negedge clk);
                // monitor has queued this cycle's records by the next rising edge
                @(posedge clk);
                if (rec_q.size() != 0) begin
                    $display("ERROR: %s: %0d unexpected output records", name, rec_q.size());
                    note_error();
                    rec_q.delete();
                end
            end
            "T": begin
                tests++;
                if (test_errs == 0) begin
                    $display("test %s: ok", name);
                end else begin
                    $display("test %s: %0d errors", name, test_errs);
                    failed_tests++;
                end
                test_errs = 0;
            end
            default: begin
                $display("ERROR: unknown expectation %s in stimulus file", op);
                note_error();
            end
        endcase
    endtask

    task automatic run_command(input string line);
        string       op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        void'($sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5));
        @(posedge clk);
        case (op)
            "A": begin
                alloc_valid     <= 1'b1;
                alloc_dst       <= f1[REG_W-1:0];
                alloc_pc        <= f2;
                alloc_is_branch <= f3[0];
                alloc_is_store  <= f4[0];
                alloc_msize     <= f5[MSIZE_W-1:0];
            end
            "CA": begin
                alu_cpl_valid <= 1'b1;
                alu_cpl_addr  <= f1[AW-1:0];
                alu_cpl_data  <= f2;
                alu_cpl_exc   <= f3[0];
            end
            "CM": begin
                mem_cpl_valid <= 1'b1;
                mem_cpl_addr  <= f1[AW-1:0];
                mem_cpl_maddr <= f2;
                mem_cpl_wdata <= f3;
                mem_cpl_exc   <= f4[0];
            end
            "CB": begin
                br_cpl_valid  <= 1'b1;
                br_cpl_addr   <= f1[AW-1:0];
                br_cpl_target <= f2;
                br_cpl_taken  <= f3[0];
                br_cpl_exc    <= f4[0];
            end
            "D": d_data_ok <= f1[0];
            "F": flush <= 1'b1;
            "I": ;
            default: begin
                $display("ERROR: unknown command %s in stimulus file", op);
                note_error();
            end
        endcase
        @(posedge clk);
        clear_strobes();
        if (op == "I") begin
            repeat (f1) @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        alloc_valid = 1'b0;
        alloc_dst = '0;
        alloc_pc = '0;
        alloc_is_branch = 1'b0;
        alloc_is_store = 1'b0;
        alloc_msize = '0;
        alu_cpl_valid = 1'b0;
        alu_cpl_addr = '0;
        alu_cpl_data = '0;
        alu_cpl_exc = 1'b0;
        mem_cpl_valid = 1'b0;
        mem_cpl_addr = '0;
        mem_cpl_maddr = '0;
        mem_cpl_wdata = '0;
        mem_cpl_exc = 1'b0;
        br_cpl_valid = 1'b0;
        br_cpl_addr = '0;
        br_cpl_target = '0;
        br_cpl_taken = 1'b0;
        br_cpl_exc = 1'b0;
        src_addr = '0;
        d_data_ok = 1'b0;
        errors = 0;
        test_errs = 0;
        tests = 0;
        failed_tests = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("testbench/rob_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file testbench/rob_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    if (line.substr(0, 0) == "E" || line.substr(0, 0) == "T") begin
                        run_expect(line);
                    end else begin
                        run_command(line);
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/rob_input.txt
# commands (hex): A dst pc is_branch is_store msize | CA addr data exc | CM addr maddr wdata exc
# CB addr target taken exc | D level | F | I cycles | expect: ER/ES/ED/EX/EO/EA/EE name fields | T name
A 1 100 0 0 0
A 2 104 0 0 0
A 3 108 0 0 0
CA 2 33 0
CA 1 22 0
EE ooo_retire
CA 0 11 0
ER ooo_retire 1 11
ER ooo_retire 2 22
ER ooo_retire 3 33
EE ooo_retire
T ooo_retire
A 5 110 0 0 0
A 4 114 0 0 0
EO operand 4 0 0
CA 4 44 0
EO operand 4 1 44
CA 3 55 0
ER operand 5 55
ER operand 4 44
EE operand
T operand
A 0 200 0 1 2
A 6 204 0 0 0
CA 6 66 0
CM 5 1000 deadbeef 0
ES store 1000 deadbeef 2
I 4
EE store
D 1
ER store 0 deadbeef
ER store 6 66
D 0
EE store
T store
A 7 300 1 0 0
A 8 304 0 0 0
A 9 308 0 0 0
CA 1 99 0
CA 0 88 0
CB 7 400 1 0
ER branch 7 308
ED branch 400
I 3
EE branch
EA branch 1 0
T branch
A a 500 0 0 0
A b 504 0 0 0
CA 1 bb 0
CA 0 bad 1
EX exception 500
I 2
EE exception
EA exception 1 0
T exception
A 10 600 0 0 0
A 11 604 0 0 0
A 12 608 0 0 0
A 13 60c 0 0 0
A 14 610 0 0 0
A 15 614 0 0 0
A 16 618 0 0 0
A 17 61c 0 0 0
EA full 0 0
A 1f 620 0 0 0
EA full 0 0
CA 0 60 0
ER full 10 60
EA full 1 0
F
EA full 1 0
EE full
T full

// File: rob.f
rtl/rob_pkg.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_table.sv
rtl/rob_retire_fsm.sv
rtl/rob_top.sv
testbench/rob_chk.sv
testbench/tb_rob.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rob -f rob.f -o sim_rob
./obj_dir/sim_rob | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
